/* project.f */
source/icache_pkg.sv
source/mem_bus_if.sv
source/icache_way_ram.sv
source/icache_tag_store.sv
source/icache.sv
source/mem_arbiter.sv
source/line_mem.sv
source/fetch_top.sv
test/fetch_props.sv
test/fetch_checker.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fetch testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb \
	-f project.f --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^sim passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* source/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int WAYS        = icache_pkg::WAYS,
	parameter int SETS_LOG2   = icache_pkg::SETS_LOG2,
	parameter int MEM_LATENCY = icache_pkg::MEM_LATENCY_DEF
) (
	input  logic              clk,
	input  logic              rst,
	// fetch side
	input  logic              fetch_valid,
	input  icache_pkg::addr_t fetch_addr,
	input  logic              advance,
	input  logic              flush,
	output icache_pkg::inst_t inst,
	output logic              inst_valid,
	output logic              busy,
	// program load side
	input  logic              load_req,
	input  icache_pkg::addr_t load_addr,
	input  icache_pkg::line_t load_line,
	output logic              load_ack
);

	mem_bus_if refill_bus ();
	mem_bus_if load_bus ();
	mem_bus_if mem_bus ();

	assign load_bus.req       = load_req;
	assign load_bus.we        = 1'b1;             // loads always write
	assign load_bus.line_addr = load_addr[31:4];
	assign load_bus.wdata     = load_line;
	assign load_ack           = load_bus.ack;

	icache #(.WAYS(WAYS), .SETS_LOG2(SETS_LOG2)) u_icache (
		.clk, .rst, .fetch_valid, .fetch_addr, .advance, .flush,
		.inst, .inst_valid, .busy, .mem(refill_bus)
	);

	mem_arbiter u_arb (.clk, .rst, .load_port(load_bus), .refill_port(refill_bus), .mem(mem_bus));

	line_mem #(.MEM_LATENCY(MEM_LATENCY)) u_mem (.clk, .rst, .bus(mem_bus));

endmodule

`default_nettype wire

/* source/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
	parameter int WAYS      = icache_pkg::WAYS,
	parameter int SETS_LOG2 = icache_pkg::SETS_LOG2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_valid,
	input  icache_pkg::addr_t fetch_addr,
	input  logic              advance,
	input  logic              flush,
	output icache_pkg::inst_t inst,
	output logic              inst_valid,
	output logic              busy,
	mem_bus_if.master         mem
);

	typedef enum logic [1:0] {IDLE, REFILL, DONE} state_t;

	state_t                  state;
	icache_pkg::fetch_addr_u fa, req_addr;
	logic [WAYS-1:0]         hit_way, hit_prev, victim_way;
	logic                    accept, fill, killed, dump;
	logic [SETS_LOG2-1:0]    ram_index;
	icache_pkg::line_t       way_rdata [WAYS];
	icache_pkg::line_t       fill_line, sel_line;
	icache_pkg::inst_t       sel_inst, held_inst;

	assign fa.raw = fetch_addr;
	assign accept = fetch_valid && advance && !flush && (state == IDLE); // flush drops a same-cycle request
	assign fill   = (state == REFILL) && mem.ack;
	assign busy   = (state != IDLE);

	assign mem.req       = (state == REFILL);
	assign mem.we        = 1'b0; // refill port only reads
	assign mem.line_addr = req_addr.raw[31:4];
	assign mem.wdata     = '0;

	icache_tag_store #(.WAYS(WAYS), .SETS_LOG2(SETS_LOG2)) u_tags (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (fa),
		.hit_way     (hit_way),
		.fill        (fill),
		.fill_addr   (req_addr),
		.frozen      (!advance),
		.victim_way  (victim_way)
	);

	assign ram_index = fill ? req_addr.f.index[SETS_LOG2-1:0] : fa.f.index[SETS_LOG2-1:0];

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_way_ram #(.SETS_LOG2(SETS_LOG2)) u_ram (
			.clk   (clk),
			.en    ((accept && hit_way[w]) || (fill && victim_way[w])),
			.we    (fill),
			.index (ram_index),
			.wdata (mem.rdata),
			.rdata (way_rdata[w])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch / refill control
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= IDLE;
			inst_valid <= 1'b0;
			killed     <= 1'b0;
			hit_prev   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						hit_prev   <= hit_way;   // zero on a miss, selects fill_line
						inst_valid <= |hit_way;
						killed     <= 1'b0;
						if (!(|hit_way)) state <= REFILL;
					end else if (advance) begin
						inst_valid <= 1'b0;      // output consumed or flushed
					end
				end
				REFILL: begin
					if (advance && flush) killed <= 1'b1;
					if (mem.ack) begin
						if (advance) begin
							state      <= IDLE;
							inst_valid <= !(killed || flush);
						end else begin
							state <= DONE;           // line is in, output waits for advance
						end
					end
				end
				DONE: begin
					if (advance) begin
						state      <= IDLE;
						inst_valid <= !(killed || flush);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) req_addr <= fa;
		if (fill) fill_line <= mem.rdata; // forwarded word comes from here
	end

	always_comb begin
		sel_line = fill_line;
		for (int w = 0; w < WAYS; w++) begin
			if (hit_prev[w]) sel_line = way_rdata[w];
		end
	end

	assign sel_inst = sel_line[{req_addr.f.word, 5'b0} +: 32];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hold copy while the next stage stalls
	always_ff @(posedge clk) begin
		if (rst) dump <= 1'b0;
		else     dump <= !advance;
	end

	always_ff @(posedge clk) begin
		if (!dump) held_inst <= sel_inst; // freezes at the first stalled edge
	end

	assign inst = dump ? held_inst : sel_inst;

endmodule

`default_nettype wire

/* source/icache_pkg.sv */
`default_nettype none

package icache_pkg;

	// default sizes, overridden from the top level
	localparam int WAYS            = 4;
	localparam int SETS_LOG2       = 6;
	localparam int MEM_LATENCY_DEF = 3;
	localparam int LINE_ADDR_W     = 28; // byte address minus 4 offset bits

	typedef logic [31:0]              addr_t;
	typedef logic [LINE_ADDR_W-1:0]   line_addr_t;
	typedef logic [127:0]             line_t;
	typedef logic [31:0]              inst_t;

	typedef struct packed {
		logic [21:0] tag;
		logic [5:0]  index;
		logic [1:0]  word;     // instruction within the line
		logic [1:0]  byte_sel;
	} fetch_fields_t;

	// one fetch address, seen raw or split into cache fields
	typedef union packed {
		addr_t         raw;
		fetch_fields_t f;
	} fetch_addr_u;

endpackage

`default_nettype wire

/* source/icache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
	parameter int WAYS      = icache_pkg::WAYS,
	parameter int SETS_LOG2 = icache_pkg::SETS_LOG2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::fetch_addr_u lookup_addr,
	output logic [WAYS-1:0]         hit_way,
	input  logic                    fill,
	input  icache_pkg::fetch_addr_u fill_addr,
	input  logic                    frozen,
	output logic [WAYS-1:0]         victim_way
);

	localparam int SETS  = 2**SETS_LOG2;
	localparam int TAG_W = icache_pkg::LINE_ADDR_W - SETS_LOG2;

	logic [TAG_W-1:0]     tags [WAYS][SETS];
	logic [SETS-1:0]      valid [WAYS];
	logic                 rotate_pending;
	logic [SETS_LOG2-1:0] lookup_index, fill_index;
	logic [TAG_W-1:0]     lookup_tag, fill_tag;

	assign lookup_index = lookup_addr.f.index[SETS_LOG2-1:0];
	assign fill_index   = fill_addr.f.index[SETS_LOG2-1:0];
	assign lookup_tag   = lookup_addr.raw[31 -: TAG_W]; // everything above the index
	assign fill_tag     = fill_addr.raw[31 -: TAG_W];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit_way[w] = valid[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < WAYS; w++) begin
				if (victim_way[w]) valid[w][fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (fill && victim_way[w]) tags[w][fill_index] <= fill_tag;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// victim rotation, a fill during a stall rotates once the stall ends
	always_ff @(posedge clk) begin
		if (rst) begin
			victim_way     <= WAYS'(1);
			rotate_pending <= 1'b0;
		end else if ((fill || rotate_pending) && !frozen) begin
			victim_way     <= {victim_way[WAYS-2:0], victim_way[WAYS-1]};
			rotate_pending <= 1'b0;
		end else if (fill) begin
			rotate_pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/icache_way_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way_ram #(
	parameter int SETS_LOG2 = icache_pkg::SETS_LOG2
) (
	input  logic                 clk,
	input  logic                 en,
	input  logic                 we,
	input  logic [SETS_LOG2-1:0] index,
	input  icache_pkg::line_t    wdata,
	output icache_pkg::line_t    rdata
);

	icache_pkg::line_t cells [2**SETS_LOG2];

	// single port, a write cycle leaves rdata untouched
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				cells[index] <= wdata;
			end else begin
				rdata <= cells[index];
			end
		end
	end

endmodule

`default_nettype wire

/* source/line_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module line_mem #(
	parameter int MEM_LATENCY = icache_pkg::MEM_LATENCY_DEF
) (
	input  logic     clk,
	input  logic     rst,
	mem_bus_if.slave bus
);

	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	icache_pkg::line_t lines [256];
	logic [CNT_W-1:0]  count;
	logic [7:0]        index;
	logic              done;

	assign index = bus.line_addr[7:0]; // upper line bits alias
	assign done  = bus.req && !bus.ack && (count == CNT_W'(MEM_LATENCY - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			count   <= '0;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= done;
			if (done)                    count <= '0;
			else if (bus.req && !bus.ack) count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			if (bus.we) lines[index] <= bus.wdata;
			else        bus.rdata    <= lines[index];
		end
	end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic      clk,
	input  logic      rst,
	mem_bus_if.slave  load_port,
	mem_bus_if.slave  refill_port,
	mem_bus_if.master mem
);

	logic active;     // grant held
	logic owner_load; // 1 = load port owns the bus
	logic settle;     // cycle after ack, master drops req here

	always_ff @(posedge clk) begin
		if (rst) begin
			active     <= 1'b0;
			owner_load <= 1'b0;
			settle     <= 1'b0;
		end else begin
			settle <= mem.ack;
			if (active) begin
				if (mem.ack) active <= 1'b0;
			end else if (!settle) begin
				if (load_port.req) begin // load wins a tie
					active     <= 1'b1;
					owner_load <= 1'b1;
				end else if (refill_port.req) begin
					active     <= 1'b1;
					owner_load <= 1'b0;
				end
			end
		end
	end

	assign mem.req       = active;
	assign mem.we        = owner_load ? load_port.we        : refill_port.we;
	assign mem.line_addr = owner_load ? load_port.line_addr : refill_port.line_addr;
	assign mem.wdata     = owner_load ? load_port.wdata     : refill_port.wdata;

	assign load_port.ack   = mem.ack && owner_load;
	assign refill_port.ack = mem.ack && !owner_load;
	assign load_port.rdata   = mem.rdata; // broadcast, ack qualifies it
	assign refill_port.rdata = mem.rdata;

endmodule

`default_nettype wire

/* source/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one master-to-memory line port
interface mem_bus_if;
	logic                   req;       // level, held until ack
	logic                   we;
	icache_pkg::line_addr_t line_addr;
	icache_pkg::line_t      wdata;
	icache_pkg::line_t      rdata;     // valid during ack
	logic                   ack;       // single-cycle pulse

	modport master (output req, we, line_addr, wdata, input rdata, ack);
	modport slave  (input req, we, line_addr, wdata, output rdata, ack);
endinterface

`default_nettype wire

/* test/fetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
	input logic              clk,
	input logic              rst,
	input logic              inst_valid,
	input logic              advance,
	input logic              flush,
	input icache_pkg::inst_t inst
);

	icache_pkg::inst_t exp_q [$]; // filled by the testbench, one per fetch
	int                compares = 0;
	int                errors   = 0;

	task automatic expect_inst(icache_pkg::inst_t value);
		exp_q.push_back(value);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// the next stage takes inst at the edge after this sample
	always @(negedge clk) begin : compare
		icache_pkg::inst_t want;
		if (!rst && inst_valid && advance && !flush) begin
			if (exp_q.size() == 0) begin
				$display("inst_valid at %0t with no fetch outstanding, inst %h", $time, inst);
				errors++;
			end else begin
				want = exp_q.pop_front();
				compares++;
				if (inst !== want) begin
					$display("ERROR %0t: inst expected %h, got %h", $time, want, inst);
					errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/fetch_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_props (
	input logic              clk,
	input logic              rst,
	input logic              fetch_valid,
	input logic              advance,
	input logic              busy,
	input logic              inst_valid,
	input icache_pkg::inst_t inst
);

	int failures = 0; // failed assertion count

	// front end keeps fetch_valid low during a refill
	no_fetch_while_busy: assert property (
		@(posedge clk) disable iff (rst) busy |-> !fetch_valid
	) else begin
		$error("fetch_valid high while the cache is busy");
		failures++;
	end

	no_output_while_busy: assert property (
		@(posedge clk) disable iff (rst) busy |-> !inst_valid
	) else begin
		$error("inst_valid high while the cache is busy");
		failures++;
	end

	// stalled output holds
	hold_on_stall: assert property (
		@(posedge clk) disable iff (rst) !advance |=> $stable(inst_valid) && $stable(inst)
	) else begin
		$error("inst or inst_valid changed while advance was low");
		failures++;
	end

endmodule

bind icache fetch_props u_props (
	.clk         (clk),
	.rst         (rst),
	.fetch_valid (fetch_valid),
	.advance     (advance),
	.busy        (busy),
	.inst_valid  (inst_valid),
	.inst        (inst)
);

`default_nettype wire

/* test/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int WAIT_LIMIT = 60; // cycles per wait
	localparam int MISS = 0;
	localparam int HIT  = 1;

	// line groups, one slot each in line_mem
	localparam icache_pkg::addr_t BASE_LINES  = 32'h0000_1000; // indices 0..3
	localparam icache_pkg::addr_t STALL_LINE  = 32'h0004_0080;
	localparam icache_pkg::addr_t FLUSH_LINE  = 32'h0004_0090;
	localparam icache_pkg::addr_t REFILL_LINE = 32'h0004_00a0;
	localparam icache_pkg::addr_t FRESH_LINE  = 32'h0004_00b0; // loaded during a refill

	logic              clk;
	logic              rst;
	logic              fetch_valid;
	icache_pkg::addr_t fetch_addr;
	logic              advance;
	logic              flush;
	icache_pkg::inst_t inst;
	logic              inst_valid;
	logic              busy;
	logic              load_req;
	icache_pkg::addr_t load_addr;
	icache_pkg::line_t load_line;
	logic              load_ack;

	icache_pkg::line_t shadow [256]; // line_mem has 256 lines, higher line bits alias
	int                other_errors = 0;

	fetch_top #(.WAYS(4), .SETS_LOG2(6), .MEM_LATENCY(3)) u_dut (
		.clk, .rst, .fetch_valid, .fetch_addr, .advance, .flush,
		.inst, .inst_valid, .busy, .load_req, .load_addr, .load_line, .load_ack
	);

	fetch_checker u_chk (.clk, .rst, .inst_valid, .advance, .flush, .inst);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic icache_pkg::line_t random_line();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// lines sharing cache index 21, tag t
	function automatic icache_pkg::addr_t conflict_addr(int t);
		return (icache_pkg::addr_t'(t) << 10) | 32'h0000_0150;
	endfunction

	// instruction that the fetch of addr must return
	function automatic icache_pkg::inst_t expected_inst(icache_pkg::addr_t addr);
		icache_pkg::fetch_addr_u fa;
		icache_pkg::line_t       line;
		fa.raw = addr;
		line   = shadow[fa.raw[11:4]];
		return line[int'(fa.f.word) * 32 +: 32];
	endfunction

	task automatic load_line_at(icache_pkg::addr_t addr, icache_pkg::line_t data);
		int cycles;
		cycles    = 0;
		load_req  = 1'b1;
		load_addr = addr;
		load_line = data;
		@(negedge clk);
		while (!load_ack && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!load_ack) begin
			$display("load of line %h was never acknowledged", addr);
			other_errors++;
		end else begin
			shadow[addr[11:4]] = data;
		end
		step();
		load_req = 1'b0; // one cycle after ack
	endtask

	task automatic fetch(icache_pkg::addr_t addr, int mode, bit keep, bit kill);
		int cycles;
		cycles      = 0;
		fetch_valid = 1'b1;
		fetch_addr  = addr;
		if (keep) u_chk.expect_inst(expected_inst(addr));
		step();                 // request taken at this edge
		fetch_valid = 1'b0;
		flush       = kill;
		if (mode == HIT && (busy || !inst_valid)) begin
			$display("fetch of %h at %0t did not hit", addr, $time);
			other_errors++;
		end
		if (mode == MISS && !busy) begin
			$display("fetch of %h at %0t did not miss", addr, $time);
			other_errors++;
		end
		step();
		flush = 1'b0;
		while (busy && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		if (busy) begin
			$display("timeout waiting for the refill of %h", addr);
			other_errors++;
		end else if (kill && inst_valid) begin
			$display("flushed fetch of %h still raised inst_valid", addr);
			other_errors++;
		end
	endtask

	// hold the next stage off while an instruction is pending
	task automatic stall(int cycles);
		icache_pkg::inst_t first;
		first = inst;
		if (!inst_valid) begin
			$display("no instruction was pending when advance dropped at %0t", $time);
			other_errors++;
		end
		advance = 1'b0;
		repeat (cycles) begin
			step();
			if (inst !== first) begin
				$display("ERROR %0t: inst expected %h, got %h", $time, first, inst);
				other_errors++;
			end
			if (inst_valid !== 1'b1) begin
				$display("ERROR %0t: inst_valid expected 1, got %b", $time, inst_valid);
				other_errors++;
			end
		end
		advance = 1'b1;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence

	initial begin
		int assert_errors;
		void'($urandom(24));
		rst         = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr  = '0;
		advance     = 1'b1;
		flush       = 1'b0;
		load_req    = 1'b0;
		load_addr   = '0;
		load_line   = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		if (inst_valid || busy || load_ack) begin
			$display("outputs not idle after reset");
			other_errors++;
		end

		for (int k = 0; k < 4; k++) load_line_at(BASE_LINES + k * 16, random_line());
		for (int t = 1; t <= 4; t++) load_line_at(conflict_addr(t), random_line()); // tag 5 aliases tag 1
		load_line_at(STALL_LINE, random_line());
		load_line_at(FLUSH_LINE, random_line());
		load_line_at(REFILL_LINE, random_line());

		// cold misses, then hits on other words
		for (int k = 0; k < 4; k++) fetch(BASE_LINES + k * 20, MISS, 1'b1, 1'b0);
		for (int k = 0; k < 4; k++) fetch(BASE_LINES + k * 16 + (3 - k) * 4, HIT, 1'b1, 1'b0);

		// five tags on one set, then back in reverse
		// only the first tag has been rotated out by the fifth
		for (int t = 1; t <= 5; t++) begin
			fetch(conflict_addr(t) + ($urandom() % 4) * 4, MISS, 1'b1, 1'b0);
		end
		for (int t = 5; t >= 1; t--) begin
			fetch(conflict_addr(t) + ($urandom() % 4) * 4, (t == 1) ? MISS : HIT,
				1'b1, 1'b0);
		end

		fetch(STALL_LINE, MISS, 1'b1, 1'b0);
		stall(2 + $urandom() % 6);
		fetch(STALL_LINE + 4, HIT, 1'b1, 1'b0);

		fetch(FLUSH_LINE, MISS, 1'b0, 1'b1);     // flushed during the refill
		fetch(FLUSH_LINE + 4, HIT, 1'b1, 1'b0);  // line arrived anyway
		fetch(STALL_LINE + 8, HIT, 1'b0, 1'b1);  // flushed hit
		fetch(STALL_LINE + 12, HIT, 1'b1, 1'b0);

		fork
			fetch(REFILL_LINE + 4, MISS, 1'b1, 1'b0);
			begin
				repeat (2) step();
				load_line_at(FRESH_LINE, random_line());
			end
		join
		fetch(FRESH_LINE + 8, MISS, 1'b1, 1'b0);

		repeat (4) step();
		if (u_chk.pending() != 0) begin
			$display("%0d expected instructions were never returned", u_chk.pending());
			other_errors++;
		end
		assert_errors = u_dut.u_icache.u_props.failures;
		$display("checks %0d, errors: checker %0d, testbench %0d, assertions %0d",
			u_chk.compares, u_chk.errors, other_errors, assert_errors);
		if (u_chk.errors == 0 && other_errors == 0 && assert_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
